//--- Bender.yml
package:
  name: tart_correlator

sources:
  - hw/tart_sig_pkg.sv
  - hw/tart_corr_pkg.sv
  - hw/accum_sdp_ram.sv
  - hw/correlate_cos_sin.sv
  - hw/corr_slot_sequencer.sv
  - hw/correlator_block.sv
  - hw/visibility_capture.sv
  - hw/tart_correlator_top.sv
  - target: test
    files:
      - tb/tb_tart_correlator.sv

//--- build.f
hw/tart_sig_pkg.sv
hw/tart_corr_pkg.sv
hw/accum_sdp_ram.sv
hw/correlate_cos_sin.sv
hw/corr_slot_sequencer.sv
hw/correlator_block.sv
hw/visibility_capture.sv
hw/tart_correlator_top.sv
tb/tb_tart_correlator.sv

//--- hw/accum_sdp_ram.sv
`timescale 1ns/100ps

module accum_sdp_ram (
   input  logic                  clk_x,
   input  logic                  we,
   input  tart_corr_pkg::slot_t  waddr,
   input  tart_corr_pkg::accum_t wdata,
   input  tart_corr_pkg::slot_t  raddr,
   output tart_corr_pkg::accum_t rdata
);

   // One entry per possible slot address
   localparam int depth = 2 ** $bits(tart_corr_pkg::slot_t);

   tart_corr_pkg::accum_t mem [depth];

   // -------------------------------------------------------------------
   // Write port
   // -------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // -------------------------------------------------------------------
   // Read port, asynchronous
   // -------------------------------------------------------------------

   // Distributed RAM, old sum ready in the same cycle
   assign rdata = mem[raddr];

endmodule

//--- hw/corr_slot_sequencer.sv
`timescale 1ns/100ps

module corr_slot_sequencer (
   input  logic                     clk_x,
   input  logic                     rst_n,
   input  logic                     sample_stb,
   input  tart_sig_pkg::ant_word_t  re,
   input  tart_sig_pkg::ant_word_t  im,
   input  tart_corr_pkg::blk_len_t  blk_len,
   output logic                     en,
   output logic                     sw,
   output tart_corr_pkg::slot_t     rd,
   output logic                     blk_flip,
   output tart_sig_pkg::ant_word_t  re_q,
   output tart_sig_pkg::ant_word_t  im_q
);

   tart_corr_pkg::seq_state_t state;
   tart_corr_pkg::blk_len_t   smp_cnt;
   logic                      accept;
   logic                      last_slot;
   logic                      last_smp;

   // -------------------------------------------------------------------
   // Decodes
   // -------------------------------------------------------------------

   // Strobes during a run are dropped
   assign accept    = (state == tart_corr_pkg::seq_idle) && sample_stb;
   assign last_slot = (rd == tart_corr_pkg::slot_t'(tart_corr_pkg::num_slots - 1));
   // blk_len is at least 1, so no underflow
   assign last_smp  = (smp_cnt == blk_len - 16'd1);

   // One slot per cycle while running
   assign en       = (state == tart_corr_pkg::seq_run);
   // First sample of an integration, adder starts from zero
   assign sw       = en && (smp_cnt == '0);
   // Final slot of the final sample
   assign blk_flip = en && last_slot && last_smp;

   // -------------------------------------------------------------------
   // FSM, slot counter and sample counter
   // -------------------------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         state   <= tart_corr_pkg::seq_idle;
         rd      <= '0;
         smp_cnt <= '0;
      end else begin
         case (state)
            tart_corr_pkg::seq_idle: begin
               if (sample_stb) begin
                  state <= tart_corr_pkg::seq_run;
                  rd    <= '0;
               end
            end
            tart_corr_pkg::seq_run: begin
               if (last_slot) begin
                  state <= tart_corr_pkg::seq_idle;
                  rd    <= '0;
                  // Wrap at end of integration
                  if (last_smp) begin
                     smp_cnt <= '0;
                  end else begin
                     smp_cnt <= smp_cnt + 16'd1;
                  end
               end else begin
                  rd <= rd + 4'd1;
               end
            end
            default: state <= tart_corr_pkg::seq_idle;
         endcase
      end
   end

   // Sample held for all 12 slots
   always_ff @(posedge clk_x) begin
      if (accept) begin
         re_q <= re;
         im_q <= im;
      end
   end

endmodule

//--- hw/correlate_cos_sin.sv
`timescale 1ns/100ps

module correlate_cos_sin (
   input  logic                  clk_x,
   input  logic                  rst_n,
   input  logic                  clr,
   input  logic                  en,
   input  logic                  ar,
   input  logic                  br,
   input  logic                  bi,
   input  tart_corr_pkg::accum_t dcos,
   input  tart_corr_pkg::accum_t dsin,
   output logic                  go,
   output logic                  vld,
   output tart_corr_pkg::accum_t qcos,
   output tart_corr_pkg::accum_t qsin,
   output logic                  oc,
   output logic                  os
);

   localparam int msb = tart_corr_pkg::accum_w - 1;

   tart_corr_pkg::accum_t prod_c;
   tart_corr_pkg::accum_t prod_s;
   tart_corr_pkg::accum_t old_c;
   tart_corr_pkg::accum_t old_s;
   tart_corr_pkg::accum_t sum_c;
   tart_corr_pkg::accum_t sum_s;
   logic                  wrap_c;
   logic                  wrap_s;
   tart_corr_pkg::accum_t go_cos;
   tart_corr_pkg::accum_t go_sin;
   logic                  go_oc;
   logic                  go_os;

   // -------------------------------------------------------------------
   // Sign products and adders
   // -------------------------------------------------------------------

   // Equal signs give +1, else -1 (all ones)
   assign prod_c = (ar == br) ? tart_corr_pkg::accum_t'(1) : '1;
   assign prod_s = (ar == bi) ? tart_corr_pkg::accum_t'(1) : '1;

   // First pass of an integration ignores memory contents
   assign old_c = clr ? '0 : dcos;
   assign old_s = clr ? '0 : dsin;

   assign sum_c = old_c + prod_c;
   assign sum_s = old_s + prod_s;

   // Same input signs, result sign flipped
   assign wrap_c = (old_c[msb] == prod_c[msb]) && (sum_c[msb] != old_c[msb]);
   assign wrap_s = (old_s[msb] == prod_s[msb]) && (sum_s[msb] != old_s[msb]);

   // -------------------------------------------------------------------
   // Two-stage pipeline, go then vld
   // -------------------------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         go  <= 1'b0;
         vld <= 1'b0;
         oc  <= 1'b0;
         os  <= 1'b0;
      end else begin
         go  <= en;
         vld <= go;
         // Flags only follow a live slot
         oc  <= go && go_oc;
         os  <= go && go_os;
      end
   end

   // Sums and flags, no reset
   always_ff @(posedge clk_x) begin
      if (en) begin
         go_cos <= sum_c;
         go_sin <= sum_s;
         go_oc  <= wrap_c;
         go_os  <= wrap_s;
      end
      qcos <= go_cos;
      qsin <= go_sin;
   end

endmodule

//--- hw/correlator_block.sv
`timescale 1ns/100ps

module correlator_block (
   input  logic                    clk_x,
   input  logic                    rst_n,
   input  logic                    sw,
   input  logic                    en,
   input  tart_sig_pkg::ant_word_t re,
   input  tart_sig_pkg::ant_word_t im,
   input  tart_corr_pkg::slot_t    rd,
   output logic                    vld,
   output tart_corr_pkg::slot_t    wr,
   output tart_corr_pkg::vis_t     vis,
   output logic                    overflow_cos,
   output logic                    overflow_sin
);

   tart_sig_pkg::ant_idx_t a_idx;
   tart_sig_pkg::ant_idx_t b_idx;
   logic                   ar;
   logic                   br;
   logic                   bi;
   logic                   go;
   tart_corr_pkg::slot_t   rd_q;
   tart_corr_pkg::accum_t  dcos;
   tart_corr_pkg::accum_t  dsin;
   tart_corr_pkg::accum_t  qcos;
   tart_corr_pkg::accum_t  qsin;

   // -------------------------------------------------------------------
   // Antenna pair for this slot
   // -------------------------------------------------------------------
   assign a_idx = tart_corr_pkg::pair_table[rd][0];
   assign b_idx = tart_corr_pkg::pair_table[rd][1];

   // Real part of a against real and imaginary parts of b
   assign ar = re[a_idx];
   assign br = re[b_idx];
   assign bi = im[b_idx];

   // -------------------------------------------------------------------
   // Write address, rd two cycles late
   // -------------------------------------------------------------------

   // Follows the go/vld stages of the adder
   always_ff @(posedge clk_x) begin
      if (en) begin
         rd_q <= rd;
      end
      if (go) begin
         wr <= rd_q;
      end
   end

   // -------------------------------------------------------------------
   // Adder and accumulator memories
   // -------------------------------------------------------------------
   correlate_cos_sin u_corr (
      .clk_x (clk_x),
      .rst_n (rst_n),
      .clr   (sw),
      .en    (en),
      .ar    (ar),
      .br    (br),
      .bi    (bi),
      .dcos  (dcos),
      .dsin  (dsin),
      .go    (go),
      .vld   (vld),
      .qcos  (qcos),
      .qsin  (qsin),
      .oc    (overflow_cos),
      .os    (overflow_sin)
   );

   // Cosine sums
   accum_sdp_ram u_ram_cos (
      .clk_x (clk_x),
      .we    (vld),
      .waddr (wr),
      .wdata (qcos),
      .raddr (rd),
      .rdata (dcos)
   );

   // Sine sums
   accum_sdp_ram u_ram_sin (
      .clk_x (clk_x),
      .we    (vld),
      .waddr (wr),
      .wdata (qsin),
      .raddr (rd),
      .rdata (dsin)
   );

   assign vis = {qsin, qcos};

endmodule

//--- hw/tart_corr_pkg.sv
package tart_corr_pkg;

   // -------------------------------------------------------------------
   // Time multiplexing
   // -------------------------------------------------------------------

   // Correlation slots per antenna sample
   localparam int num_slots = 12;

   // Slot index, also the accumulator address
   typedef logic [3:0] slot_t;

   // -------------------------------------------------------------------
   // Accumulators
   // -------------------------------------------------------------------

   // Width of one signed running sum
   localparam int accum_w = 12;

   // Signed cosine or sine sum, two's complement
   typedef logic signed [accum_w-1:0] accum_t;

   // Sine sum in the upper half, cosine sum in the lower half
   typedef logic [2*accum_w-1:0] vis_t;

   // Samples per integration
   typedef logic [15:0] blk_len_t;

   // -------------------------------------------------------------------
   // Antenna pairs, index 0 is antenna a, index 1 is antenna b
   // -------------------------------------------------------------------
   localparam tart_sig_pkg::ant_idx_t pair_table [num_slots][2] = '{
      '{5'd0,  5'd1},
      '{5'd0,  5'd2},
      '{5'd1,  5'd2},
      '{5'd3,  5'd4},
      '{5'd3,  5'd5},
      '{5'd4,  5'd5},
      '{5'd6,  5'd7},
      '{5'd8,  5'd9},
      '{5'd10, 5'd11},
      '{5'd12, 5'd17},
      '{5'd18, 5'd23},
      '{5'd22, 5'd23}
   };

   // Sequencer states
   typedef enum logic {
      seq_idle,
      seq_run
   } seq_state_t;

endpackage

//--- hw/tart_correlator_top.sv
`timescale 1ns/100ps

module tart_correlator_top (
   input  logic                    clk_x,
   input  logic                    rst_n,
   input  logic                    sample_stb,
   input  tart_sig_pkg::ant_word_t re,
   input  tart_sig_pkg::ant_word_t im,
   input  tart_corr_pkg::blk_len_t blk_len,
   input  tart_corr_pkg::slot_t    rd_slot,
   output tart_corr_pkg::vis_t     rd_vis,
   output logic                    rd_ovf_cos,
   output logic                    rd_ovf_sin,
   output logic                    blk_done
);

   // Sequencer to correlator
   logic                    en;
   logic                    sw;
   tart_corr_pkg::slot_t    rd;
   logic                    blk_flip;
   tart_sig_pkg::ant_word_t re_q;
   tart_sig_pkg::ant_word_t im_q;

   // Correlator to capture
   logic                    vld;
   tart_corr_pkg::slot_t    wr;
   tart_corr_pkg::vis_t     vis;
   logic                    ovf_cos;
   logic                    ovf_sin;

   // -------------------------------------------------------------------
   // Slot sequencer
   // -------------------------------------------------------------------
   corr_slot_sequencer u_seq (
      .clk_x      (clk_x),
      .rst_n      (rst_n),
      .sample_stb (sample_stb),
      .re         (re),
      .im         (im),
      .blk_len    (blk_len),
      .en         (en),
      .sw         (sw),
      .rd         (rd),
      .blk_flip   (blk_flip),
      .re_q       (re_q),
      .im_q       (im_q)
   );

   // -------------------------------------------------------------------
   // Correlator block
   // -------------------------------------------------------------------
   correlator_block u_corr (
      .clk_x        (clk_x),
      .rst_n        (rst_n),
      .sw           (sw),
      .en           (en),
      .re           (re_q),
      .im           (im_q),
      .rd           (rd),
      .vld          (vld),
      .wr           (wr),
      .vis          (vis),
      .overflow_cos (ovf_cos),
      .overflow_sin (ovf_sin)
   );

   // -------------------------------------------------------------------
   // Double-buffered capture
   // -------------------------------------------------------------------
   visibility_capture u_cap (
      .clk_x      (clk_x),
      .rst_n      (rst_n),
      .vld        (vld),
      .wr         (wr),
      .vis        (vis),
      .oc         (ovf_cos),
      .os         (ovf_sin),
      .flip       (blk_flip),
      .rd_slot    (rd_slot),
      .rd_vis     (rd_vis),
      .rd_ovf_cos (rd_ovf_cos),
      .rd_ovf_sin (rd_ovf_sin),
      .blk_done   (blk_done)
   );

endmodule

//--- hw/tart_sig_pkg.sv
package tart_sig_pkg;

   // -------------------------------------------------------------------
   // Antenna array
   // -------------------------------------------------------------------

   // Antennas in the array
   localparam int num_ant = 24;

   // Index width, enough for antenna 0 to 23
   localparam int ant_idx_w = 5;

   // -------------------------------------------------------------------
   // Sample types
   // -------------------------------------------------------------------

   // One 1-bit sample per antenna
   // Bit set is +1, bit clear is -1
   typedef logic [num_ant-1:0] ant_word_t;

   // Antenna number, selects one bit of an ant_word_t
   typedef logic [ant_idx_w-1:0] ant_idx_t;

endpackage

//--- hw/visibility_capture.sv
`timescale 1ns/100ps

module visibility_capture (
   input  logic                 clk_x,
   input  logic                 rst_n,
   input  logic                 vld,
   input  tart_corr_pkg::slot_t wr,
   input  tart_corr_pkg::vis_t  vis,
   input  logic                 oc,
   input  logic                 os,
   input  logic                 flip,
   input  tart_corr_pkg::slot_t rd_slot,
   output tart_corr_pkg::vis_t  rd_vis,
   output logic                 rd_ovf_cos,
   output logic                 rd_ovf_sin,
   output logic                 blk_done
);

   localparam int ns = tart_corr_pkg::num_slots;

   tart_corr_pkg::vis_t vis_mem [2][ns];
   logic [ns-1:0]       valid   [2];
   logic [ns-1:0]       ovf_c   [2];
   logic [ns-1:0]       ovf_s   [2];
   logic                bank;
   logic                rd_bank;
   logic [1:0]          flip_q;
   logic                rd_hit;

   // -------------------------------------------------------------------
   // Active bank, sticky flags and bank switch
   // -------------------------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         bank     <= 1'b0;
         flip_q   <= '0;
         blk_done <= 1'b0;
         valid    <= '{default: '0};
         ovf_c    <= '{default: '0};
         ovf_s    <= '{default: '0};
      end else begin
         // Flip lines up with the last vld of the sample
         flip_q   <= {flip_q[0], flip};
         blk_done <= flip_q[1];
         if (vld) begin
            valid[bank][wr] <= 1'b1;
            // First write of an integration replaces the flags
            if (valid[bank][wr]) begin
               ovf_c[bank][wr] <= ovf_c[bank][wr] | oc;
               ovf_s[bank][wr] <= ovf_s[bank][wr] | os;
            end else begin
               ovf_c[bank][wr] <= oc;
               ovf_s[bank][wr] <= os;
            end
         end
         if (flip_q[1]) begin
            bank        <= rd_bank;
            // Bank about to fill starts empty
            valid[rd_bank] <= '0;
         end
      end
   end

   // Visibility store, no reset
   always_ff @(posedge clk_x) begin
      if (vld) begin
         vis_mem[bank][wr] <= vis;
      end
   end

   // -------------------------------------------------------------------
   // Readout of the finished bank
   // -------------------------------------------------------------------
   assign rd_bank = ~bank;
   assign rd_hit  = (rd_slot < ns);

   // Unwritten entries read as zero
   assign rd_vis     = (rd_hit && valid[rd_bank][rd_slot]) ? vis_mem[rd_bank][rd_slot] : '0;
   assign rd_ovf_cos = rd_hit && ovf_c[rd_bank][rd_slot];
   assign rd_ovf_sin = rd_hit && ovf_s[rd_bank][rd_slot];

endmodule

//--- tb/corr_trace.txt
# Record: blk_len (decimal), then sample lines of re im (hex) and a repeat count (decimal)
# Then 12 lines for slots 0 to 11: cos sin (12-bit hex) overflow_cos overflow_sin
# Single sample, all antennas equal
1
ffffff ffffff 1
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
001 001 0 0
# Mixed samples, seven in all
7
000000 ffffff 3
aaaaaa 000000 2
800145 000f0f 2
fff 001 0 0
007 001 0 0
fff ff9 0 0
003 ffd 0 0
007 ffd 0 0
003 001 0 0
fff ffd 0 0
fff 001 0 0
003 ffd 0 0
003 001 0 0
fff 001 0 0
fff 001 0 0
# Long integration, wraps where the first product matches the repeated one
2049
800145 000f0f 1
aaaaaa 000000 2048
7ff 801 1 1
801 801 1 1
7ff 7ff 1 1
801 801 0 0
801 801 1 0
801 801 0 1
7ff 7ff 1 0
7ff 801 1 1
801 7ff 0 0
801 801 0 1
7ff 801 1 1
7ff 801 1 1

//--- tb/tb_tart_correlator.sv
`timescale 1ns/100ps

module tb_tart_correlator;

   localparam int ns         = tart_corr_pkg::num_slots;
   localparam int aw         = tart_corr_pkg::accum_w;
   // Strobe of the last sample to blk_done
   localparam int done_lat   = 15;
   localparam int done_limit = 64;

   // DUT ports
   logic                    clk_x = 1'b0;
   logic                    rst_n;
   logic                    sample_stb;
   tart_sig_pkg::ant_word_t re;
   tart_sig_pkg::ant_word_t im;
   tart_corr_pkg::blk_len_t blk_len;
   tart_corr_pkg::slot_t    rd_slot;
   tart_corr_pkg::vis_t     rd_vis;
   logic                    rd_ovf_cos;
   logic                    rd_ovf_sin;
   logic                    blk_done;

   // Expected sums of the integration in flight and of the finished one
   logic [aw-1:0] cur_cos  [ns];
   logic [aw-1:0] cur_sin  [ns];
   logic          cur_oc   [ns];
   logic          cur_os   [ns];
   logic [aw-1:0] prev_cos [ns];
   logic [aw-1:0] prev_sin [ns];
   logic          prev_oc  [ns];
   logic          prev_os  [ns];

   logic [15:0]   lfsr     = 16'd73;
   int            fd;
   int            mon_slot = 0;

   // 4 ns clock
   always #2 clk_x = ~clk_x;

   tart_correlator_top uut (
      .clk_x      (clk_x),
      .rst_n      (rst_n),
      .sample_stb (sample_stb),
      .re         (re),
      .im         (im),
      .blk_len    (blk_len),
      .rd_slot    (rd_slot),
      .rd_vis     (rd_vis),
      .rd_ovf_cos (rd_ovf_cos),
      .rd_ovf_sin (rd_ovf_sin),
      .blk_done   (blk_done)
   );

   // -------------------------------------------------------------------
   // Failure reporting and the compare task
   // -------------------------------------------------------------------
   task abort_run(input string why);
      if (why.len() > 0) $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("error: time %0t, %s expected %0h, actual %0h", $time, name, exp, act);
         abort_run("");
      end
   endtask

   // -------------------------------------------------------------------
   // Random idle gaps
   // -------------------------------------------------------------------

   // Galois form with taps 16, 14, 13 and 11
   function automatic logic [15:0] galois_step(input logic [15:0] s);
      if (s[0]) begin
         galois_step = (s >> 1) ^ 16'hB400;
      end else begin
         galois_step = s >> 1;
      end
   endfunction

   // One LFSR step for each of three bits
   task next_gap(output int gap);
      int i;
      gap = 0;
      for (i = 0; i < 3; i++) begin
         gap  = (gap << 1) | lfsr[0];
         lfsr = galois_step(lfsr);
      end
   endtask

   // -------------------------------------------------------------------
   // Stimulus and readout
   // -------------------------------------------------------------------

   // Next line that is neither blank nor a comment
   task read_line(output string line, output bit got);
      int code;
      got  = 1'b0;
      line = "";
      code = $fgets(line, fd);
      while (code != 0 && !got) begin
         if (line.len() > 1 && line[0] != "#") begin
            got = 1'b1;
         end else begin
            code = $fgets(line, fd);
         end
      end
   endtask

   // One-cycle strobe with the sample
   task drive_sample(input tart_sig_pkg::ant_word_t s_re, input tart_sig_pkg::ant_word_t s_im);
      @(posedge clk_x);
      sample_stb <= 1'b1;
      re         <= s_re;
      im         <= s_im;
      @(posedge clk_x);
      sample_stb <= 1'b0;
   endtask

   // Combinational readout checked half a cycle later
   task read_slot(input int slot, input logic [aw-1:0] ec, input logic [aw-1:0] es,
                  input logic eoc, input logic eos);
      @(posedge clk_x);
      rd_slot <= tart_corr_pkg::slot_t'(slot);
      @(negedge clk_x);
      check_value($sformatf("rd_vis[11:0] slot %0d", slot), ec, rd_vis[aw-1:0]);
      check_value($sformatf("rd_vis[23:12] slot %0d", slot), es, rd_vis[2*aw-1:aw]);
      check_value($sformatf("rd_ovf_cos slot %0d", slot), eoc, rd_ovf_cos);
      check_value($sformatf("rd_ovf_sin slot %0d", slot), eos, rd_ovf_sin);
      check_value("blk_done", 1'b0, blk_done);
   endtask

   // Reads the finished bank during the gap between samples
   task space_and_monitor;
      int gap;
      int i;
      next_gap(gap);
      for (i = 0; i < 11 + gap; i++) begin
         read_slot(mon_slot, prev_cos[mon_slot], prev_sin[mon_slot],
                   prev_oc[mon_slot], prev_os[mon_slot]);
         mon_slot = (mon_slot + 1) % ns;
      end
   endtask

   // Pulse expected a fixed latency after the last strobe
   task wait_blk_done;
      int n;
      n = 0;
      do begin
         @(negedge clk_x);
         n++;
      end while (blk_done !== 1'b1 && n < done_limit);
      if (blk_done !== 1'b1) abort_run("blk_done never arrived after the last sample");
      check_value("blk_done latency", done_lat, n);
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial begin
      string                   line;
      bit                      got;
      int                      len;
      int                      total;
      int                      reps;
      int                      r;
      int                      s;
      int                      eoc;
      int                      eos;
      int                      n_int;
      bit                      first;
      logic [aw-1:0]           ec;
      logic [aw-1:0]           es;
      tart_sig_pkg::ant_word_t s_re;
      tart_sig_pkg::ant_word_t s_im;

      rst_n      <= 1'b0;
      sample_stb <= 1'b0;
      re         <= '0;
      im         <= '0;
      blk_len    <= 16'd1;
      rd_slot    <= '0;
      n_int      = 0;
      for (s = 0; s < ns; s++) begin
         prev_cos[s] = '0;
         prev_sin[s] = '0;
         prev_oc[s]  = 1'b0;
         prev_os[s]  = 1'b0;
      end
      fd = $fopen("tb/corr_trace.txt", "r");
      if (fd == 0) abort_run("cannot open the trace file tb/corr_trace.txt");

      repeat (2) @(posedge clk_x);
      rst_n <= 1'b1;
      repeat (3) @(posedge clk_x);

      // Inactive bank after reset reads zero
      for (s = 0; s < ns; s++) begin
         read_slot(s, prev_cos[s], prev_sin[s], prev_oc[s], prev_os[s]);
      end

      read_line(line, got);
      while (got) begin
         if ($sscanf(line, "%d", len) != 1 || len < 1) abort_run("bad blk_len line in trace");
         @(posedge clk_x);
         blk_len <= tart_corr_pkg::blk_len_t'(len);
         total = 0;
         first = 1'b1;
         mon_slot = 0;
         while (total < len) begin
            read_line(line, got);
            if (!got) abort_run("trace ended inside a sample list");
            if ($sscanf(line, "%h %h %d", s_re, s_im, reps) != 3 || reps < 1) begin
               abort_run("bad sample line in trace");
            end
            for (r = 0; r < reps; r++) begin
               if (!first) space_and_monitor();
               first = 1'b0;
               drive_sample(s_re, s_im);
            end
            total += reps;
         end
         if (total != len) abort_run("sample count in trace does not match blk_len");

         // Expected sums for slots 0 to 11
         for (s = 0; s < ns; s++) begin
            read_line(line, got);
            if (!got) abort_run("trace ended inside the expected values");
            if ($sscanf(line, "%h %h %d %d", ec, es, eoc, eos) != 4) begin
               abort_run("bad expected line in trace");
            end
            cur_cos[s] = ec;
            cur_sin[s] = es;
            cur_oc[s]  = eoc[0];
            cur_os[s]  = eos[0];
         end

         wait_blk_done();
         for (s = 0; s < ns; s++) begin
            read_slot(s, cur_cos[s], cur_sin[s], cur_oc[s], cur_os[s]);
         end
         // Finished bank becomes the reference for the next integration
         prev_cos = cur_cos;
         prev_sin = cur_sin;
         prev_oc  = cur_oc;
         prev_os  = cur_os;
         n_int++;
         read_line(line, got);
      end
      $fclose(fd);

      if (n_int > 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("no integration was read from the trace");
         $display("Simulation finished: FAIL");
         $fatal(1, "run stopped with errors");
      end
   end

endmodule
